//--- Makefile
# Verilator build and run for the unit multiplexer testbench

VERILATOR ?= verilator
TOP       ?= tb_unit_mux
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --assert -Wno-fatal -j 0
PASS_MSG  ?= Test completed successfully

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

# Rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# Fails unless the pass message appears as a line of its own
run: $(SIM)
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- filelist.f
rtl/unit_pkg.sv
rtl/pipe_pkg.sv
rtl/unit_decode.sv
rtl/unit_queue.sv
rtl/alu_unit.sv
rtl/mul_unit.sv
rtl/result_select.sv
rtl/unit_mux_top.sv
testbench/tb_clock_gen.sv
testbench/tb_unit_mux.sv

//--- rtl/alu_unit.sv
////////////////////////////////////////////////////////////////////////////
// Single-cycle ALU with one output register; result held until drained.
// Multiply opcodes are not expected here and give zero.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module alu_unit (
    input  logic                 clk_i,
    input  logic                 rst_n_i,

    input  logic                 valid_i,
    output logic                 ready_o,
    input  pipe_pkg::instr_req_t req_i,

    output logic                 res_valid_o,
    input  logic                 res_ready_i,
    output pipe_pkg::instr_res_t res_o
);

    logic                        valid_q;
    pipe_pkg::instr_res_t        res_q;
    logic [unit_pkg::DATA_W-1:0] alu_data;

    always_comb begin
        unique case (req_i.op)
            unit_pkg::OP_ADD: alu_data = req_i.a + req_i.b;
            unit_pkg::OP_SUB: alu_data = req_i.a - req_i.b;
            unit_pkg::OP_AND: alu_data = req_i.a & req_i.b;
            unit_pkg::OP_OR:  alu_data = req_i.a | req_i.b;
            unit_pkg::OP_XOR: alu_data = req_i.a ^ req_i.b;
            default:          alu_data = '0;
        endcase
    end

    // Register is free when empty or drained in this cycle
    assign ready_o     = !valid_q || res_ready_i;
    assign res_valid_o = valid_q;
    assign res_o       = res_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else if (ready_o) begin
            valid_q <= valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (valid_i && ready_o) begin
            res_q.id   <= req_i.id;
            res_q.data <= alu_data;
        end
    end

endmodule

//--- rtl/mul_unit.sv
////////////////////////////////////////////////////////////////////////////
// Unsigned multiplier, MUL_STAGES deep (at least 1). The whole pipeline
// stalls while the last stage is held, so bubbles are not squeezed out.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module mul_unit #(
    parameter int unsigned MUL_STAGES = 3
) (
    input  logic                 clk_i,
    input  logic                 rst_n_i,

    input  logic                 valid_i,
    output logic                 ready_o,
    input  pipe_pkg::instr_req_t req_i,

    output logic                 res_valid_o,
    input  logic                 res_ready_i,
    output pipe_pkg::instr_res_t res_o
);

    typedef struct packed {
        logic [unit_pkg::ID_W-1:0]     id;
        logic                          hi;
        logic [2*unit_pkg::DATA_W-1:0] prod;
    } stage_t;

    logic   [MUL_STAGES-1:0] valid_q;
    stage_t                  stage_q [MUL_STAGES];
    stage_t                  stage_in;
    stage_t                  last;
    logic                    advance;

    assign stage_in.id   = req_i.id;
    assign stage_in.hi   = (req_i.op == unit_pkg::OP_MULH);
    assign stage_in.prod = req_i.a * req_i.b;

    assign advance = !valid_q[MUL_STAGES-1] || res_ready_i;
    assign ready_o = advance;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_q <= '0;
        end else if (advance) begin
            // New valid enters stage 0, the oldest falls off the top
            valid_q <= MUL_STAGES'({valid_q, valid_i});
        end
    end

    always_ff @(posedge clk_i) begin
        if (advance) begin
            stage_q[0] <= stage_in;
            for (int k = 1; k < MUL_STAGES; k++) begin
                stage_q[k] <= stage_q[k-1];
            end
        end
    end

    assign last        = stage_q[MUL_STAGES-1];
    assign res_valid_o = valid_q[MUL_STAGES-1];
    assign res_o.id    = last.id;
    assign res_o.data  = last.hi ? last.prod[2*unit_pkg::DATA_W-1:unit_pkg::DATA_W]
                                 : last.prod[unit_pkg::DATA_W-1:0];

    // A result that is not taken stays put until the result stage takes it
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (res_valid_o && !res_ready_i) |=> (res_valid_o && $stable(res_o)))
        else $error("multiplier result changed while held");

endmodule

//--- rtl/pipe_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Payloads of the request and result valid/ready pipes.
// Request is 70 bits and result 35 bits with the default widths.
////////////////////////////////////////////////////////////////////////////

package pipe_pkg;

    // Request into the multiplexer
    typedef struct packed {
        logic [unit_pkg::ID_W-1:0]   id;
        unit_pkg::op_e               op;
        logic [unit_pkg::DATA_W-1:0] a;
        logic [unit_pkg::DATA_W-1:0] b;
    } instr_req_t;

    // Result from a unit or from the multiplexer
    typedef struct packed {
        logic [unit_pkg::ID_W-1:0]   id;
        logic [unit_pkg::DATA_W-1:0] data;
    } instr_res_t;

endpackage

//--- rtl/result_select.sv
////////////////////////////////////////////////////////////////////////////
// Passes on the result of the unit named at the queue head only.
// Output data is zero whenever no result is offered.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module result_select (
    input  logic                 head_valid_i,
    input  unit_pkg::unit_e      head_unit_i,

    input  logic                 alu_valid_i,
    input  pipe_pkg::instr_res_t alu_res_i,
    input  logic                 mul_valid_i,
    input  pipe_pkg::instr_res_t mul_res_i,
    output logic                 alu_ready_o,
    output logic                 mul_ready_o,

    output logic                 out_valid_o,
    input  logic                 out_ready_i,
    output pipe_pkg::instr_res_t out_res_o,

    output logic                 deq_o
);

    logic head_alu;
    logic head_mul;

    assign head_alu = head_valid_i && (head_unit_i == unit_pkg::UNIT_ALU);
    assign head_mul = head_valid_i && (head_unit_i == unit_pkg::UNIT_MUL);

    always_comb begin
        out_valid_o = (head_alu && alu_valid_i) || (head_mul && mul_valid_i);
        out_res_o   = '0;
        if (head_alu && alu_valid_i) begin
            out_res_o = alu_res_i;
        end else if (head_mul && mul_valid_i) begin
            out_res_o = mul_res_i;
        end
    end

    // Non-head units are held back
    assign alu_ready_o = head_alu && out_ready_i;
    assign mul_ready_o = head_mul && out_ready_i;
    assign deq_o       = out_valid_o && out_ready_i;

endmodule

//--- rtl/unit_decode.sv
////////////////////////////////////////////////////////////////////////////
// Combinational dispatch. A request is taken only when both the target
// unit and the unit queue can accept it in the same cycle.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module unit_decode (
    input  logic                 in_valid_i,
    input  pipe_pkg::instr_req_t in_req_i,
    output logic                 in_ready_o,

    input  logic                 alu_ready_i,
    input  logic                 mul_ready_i,
    output logic                 alu_valid_o,
    output logic                 mul_valid_o,

    input  logic                 q_ready_i,
    output logic                 q_enq_o,
    output unit_pkg::unit_e      q_unit_o
);

    unit_pkg::unit_e target;
    logic            target_ready;

    always_comb begin
        if ((in_req_i.op == unit_pkg::OP_MUL) || (in_req_i.op == unit_pkg::OP_MULH)) begin
            target = unit_pkg::UNIT_MUL;
        end else begin
            target = unit_pkg::UNIT_ALU;
        end
        target_ready = (target == unit_pkg::UNIT_MUL) ? mul_ready_i : alu_ready_i;

        // Units see a valid only when the queue has room for the unit code
        alu_valid_o = in_valid_i & q_ready_i & (target == unit_pkg::UNIT_ALU);
        mul_valid_o = in_valid_i & q_ready_i & (target == unit_pkg::UNIT_MUL);

        q_enq_o  = in_valid_i & q_ready_i & target_ready;
        q_unit_o = target;

        // Idle input reports the queue state only
        in_ready_o = q_ready_i;
        if (in_valid_i) begin
            in_ready_o = q_ready_i & target_ready;
        end
    end

endmodule

//--- rtl/unit_mux_top.sv
////////////////////////////////////////////////////////////////////////////
// Unit multiplexer: ALU and multiplier behind one request pipe, results
// leave in request order. At most QUEUE_DEPTH instructions in flight.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module unit_mux_top #(
    parameter int unsigned QUEUE_DEPTH = 4,
    parameter int unsigned MUL_STAGES  = 3
) (
    input  logic                 clk_i,
    input  logic                 rst_n_i,

    input  logic                 in_valid_i,
    output logic                 in_ready_o,
    input  pipe_pkg::instr_req_t in_req_i,

    output logic                 out_valid_o,
    input  logic                 out_ready_i,
    output pipe_pkg::instr_res_t out_res_o
);

    logic                 alu_valid;
    logic                 alu_ready;
    logic                 mul_valid;
    logic                 mul_ready;

    logic                 q_ready;
    logic                 q_enq;
    unit_pkg::unit_e      q_unit;
    logic                 q_deq;
    logic                 head_valid;
    unit_pkg::unit_e      head_unit;

    logic                 alu_res_valid;
    logic                 alu_res_ready;
    pipe_pkg::instr_res_t alu_res;
    logic                 mul_res_valid;
    logic                 mul_res_ready;
    pipe_pkg::instr_res_t mul_res;

    unit_decode i_decode (
        .in_valid_i  ( in_valid_i ),
        .in_req_i    ( in_req_i   ),
        .in_ready_o  ( in_ready_o ),
        .alu_ready_i ( alu_ready  ),
        .mul_ready_i ( mul_ready  ),
        .alu_valid_o ( alu_valid  ),
        .mul_valid_o ( mul_valid  ),
        .q_ready_i   ( q_ready    ),
        .q_enq_o     ( q_enq      ),
        .q_unit_o    ( q_unit     )
    );

    unit_queue #(
        .QUEUE_DEPTH ( QUEUE_DEPTH )
    ) i_queue (
        .clk_i        ( clk_i      ),
        .rst_n_i      ( rst_n_i    ),
        .enq_i        ( q_enq      ),
        .enq_unit_i   ( q_unit     ),
        .enq_ready_o  ( q_ready    ),
        .deq_i        ( q_deq      ),
        .head_valid_o ( head_valid ),
        .head_unit_o  ( head_unit  )
    );

    alu_unit i_alu (
        .clk_i       ( clk_i         ),
        .rst_n_i     ( rst_n_i       ),
        .valid_i     ( alu_valid     ),
        .ready_o     ( alu_ready     ),
        .req_i       ( in_req_i      ),
        .res_valid_o ( alu_res_valid ),
        .res_ready_i ( alu_res_ready ),
        .res_o       ( alu_res       )
    );

    mul_unit #(
        .MUL_STAGES ( MUL_STAGES )
    ) i_mul (
        .clk_i       ( clk_i         ),
        .rst_n_i     ( rst_n_i       ),
        .valid_i     ( mul_valid     ),
        .ready_o     ( mul_ready     ),
        .req_i       ( in_req_i      ),
        .res_valid_o ( mul_res_valid ),
        .res_ready_i ( mul_res_ready ),
        .res_o       ( mul_res       )
    );

    result_select i_result (
        .head_valid_i ( head_valid    ),
        .head_unit_i  ( head_unit     ),
        .alu_valid_i  ( alu_res_valid ),
        .alu_res_i    ( alu_res       ),
        .mul_valid_i  ( mul_res_valid ),
        .mul_res_i    ( mul_res       ),
        .alu_ready_o  ( alu_res_ready ),
        .mul_ready_o  ( mul_res_ready ),
        .out_valid_o  ( out_valid_o   ),
        .out_ready_i  ( out_ready_i   ),
        .out_res_o    ( out_res_o     ),
        .deq_o        ( q_deq         )
    );

endmodule

//--- rtl/unit_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Operation and unit codes shared by decode and the execution units.
// Widths are fixed here; every result is DATA_W bits wide.
////////////////////////////////////////////////////////////////////////////

package unit_pkg;

    // Operand and result width
    localparam int unsigned DATA_W = 32;

    // Instruction ID width
    localparam int unsigned ID_W = 3;

    // MUL gives the low word of the unsigned product, MULH the high word
    typedef enum logic [2:0] {
        OP_ADD  = 3'd0,
        OP_SUB  = 3'd1,
        OP_AND  = 3'd2,
        OP_OR   = 3'd3,
        OP_XOR  = 3'd4,
        OP_MUL  = 3'd5,
        OP_MULH = 3'd6
    } op_e;

    typedef enum logic {
        UNIT_ALU = 1'b0,
        UNIT_MUL = 1'b1
    } unit_e;

endpackage

//--- rtl/unit_queue.sv
////////////////////////////////////////////////////////////////////////////
// In-order FIFO of unit codes, one entry per instruction in flight.
// Full reads as not ready even when a dequeue happens in the same cycle.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module unit_queue #(
    parameter int unsigned QUEUE_DEPTH = 4
) (
    input  logic            clk_i,
    input  logic            rst_n_i,

    input  logic            enq_i,
    input  unit_pkg::unit_e enq_unit_i,
    output logic            enq_ready_o,

    input  logic            deq_i,
    output logic            head_valid_o,
    output unit_pkg::unit_e head_unit_o
);

    localparam int unsigned PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int unsigned CNT_W = $clog2(QUEUE_DEPTH + 1);

    unit_pkg::unit_e mem [QUEUE_DEPTH];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(QUEUE_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign enq_ready_o  = (count != CNT_W'(QUEUE_DEPTH));
    assign head_valid_o = (count != '0);
    assign head_unit_o  = mem[rd_ptr];

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (enq_i) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (deq_i) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            if (enq_i && !deq_i) begin
                count <= count + 1'b1;
            end else if (!enq_i && deq_i) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (enq_i) begin
            mem[wr_ptr] <= enq_unit_i;
        end
    end

    // Dispatch and result selection must respect the occupancy
    assert property (@(posedge clk_i) disable iff (!rst_n_i) deq_i |-> head_valid_o)
        else $error("dequeue from empty unit queue");
    assert property (@(posedge clk_i) disable iff (!rst_n_i) enq_i |-> enq_ready_o)
        else $error("enqueue into full unit queue");

endmodule

//--- testbench/tb_clock_gen.sv
////////////////////////////////////////////////////////////////////////////
// Free-running clock and active-low reset, released on a falling edge.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_clock_gen #(
    parameter real PERIOD_NS    = 10.0,
    parameter int  RESET_CYCLES = 8
) (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2.0) clk_o = ~clk_o;
    end

    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        rst_n_o = 1'b1;
    end

endmodule

//--- testbench/tb_unit_mux.sv
////////////////////////////////////////////////////////////////////////////
// Testbench for unit_mux_top. Inputs change on the falling edge, pipe
// transfers are sampled on the rising edge. Every wait is bounded.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_unit_mux;

    // Queue shallower than the units together, so the queue sets the limit
    localparam int QUEUE_DEPTH  = 3;
    localparam int MUL_STAGES   = 3;
    localparam int TIMEOUT      = 200;
    localparam int DW           = unit_pkg::DATA_W;
    localparam int READY_HIGH   = 0;
    localparam int READY_LOW    = 1;
    localparam int READY_RANDOM = 2;

    logic                      clk;
    logic                      rst_n;
    logic                      in_valid;
    logic                      in_ready;
    pipe_pkg::instr_req_t      in_req;
    logic                      out_valid;
    logic                      out_ready;
    pipe_pkg::instr_res_t      out_res;

    logic [31:0]               rng_state;
    int                        ready_mode;
    logic [unit_pkg::ID_W-1:0] next_id;
    logic [unit_pkg::ID_W-1:0] exp_id [$];
    logic [DW-1:0]             exp_data [$];
    logic [unit_pkg::ID_W-1:0] head_id;
    logic [DW-1:0]             head_data;
    bit                        timed_out;
    int                        error_count;
    int                        check_count;
    int                        result_count;
    int                        sent_count;
    int                        test_count;
    int                        errors_at_start;
    int                        results_at_start;
    int                        sent_at_start;

    tb_clock_gen #(.PERIOD_NS(10.0), .RESET_CYCLES(8)) i_clk_gen (
        .clk_o   ( clk   ),
        .rst_n_o ( rst_n )
    );

    unit_mux_top #(
        .QUEUE_DEPTH ( QUEUE_DEPTH ),
        .MUL_STAGES  ( MUL_STAGES  )
    ) i_dut (
        .clk_i       ( clk       ),
        .rst_n_i     ( rst_n     ),
        .in_valid_i  ( in_valid  ),
        .in_ready_o  ( in_ready  ),
        .in_req_i    ( in_req    ),
        .out_valid_o ( out_valid ),
        .out_ready_i ( out_ready ),
        .out_res_o   ( out_res   )
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // Expected data straight from the operation definitions
    function automatic logic [DW-1:0] ref_result(input unit_pkg::op_e op,
                                                 input logic [DW-1:0] a,
                                                 input logic [DW-1:0] b);
        logic [2*DW-1:0] prod;
        prod = (2*DW)'(a) * (2*DW)'(b);
        case (op)
            unit_pkg::OP_ADD:  return a + b;
            unit_pkg::OP_SUB:  return a - b;
            unit_pkg::OP_AND:  return a & b;
            unit_pkg::OP_OR:   return a | b;
            unit_pkg::OP_XOR:  return a ^ b;
            unit_pkg::OP_MUL:  return prod[DW-1:0];
            unit_pkg::OP_MULH: return prod[2*DW-1:DW];
            default:           return '0;
        endcase
    endfunction

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] exp);
        $display("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
        error_count++;
    endtask

    task automatic drive_ready();
        logic [31:0] r;
        if (ready_mode == READY_RANDOM) begin
            r = next_rand();
            out_ready = r[9];
        end else begin
            out_ready = (ready_mode == READY_HIGH);
        end
    endtask

    task automatic load_request(input unit_pkg::op_e op);
        in_req.id = next_id;
        in_req.op = op;
        in_req.a  = next_rand();
        in_req.b  = next_rand();
    endtask

    // Holds the request until the rising edge that takes it
    task automatic send_request(input unit_pkg::op_e op);
        int waited;
        bit taken;
        load_request(op);
        in_valid = 1'b1;
        waited = 0;
        taken = 1'b0;
        while (!taken && waited < TIMEOUT) begin
            @(posedge clk);
            taken = in_ready;
            @(negedge clk);
            drive_ready();
            waited++;
        end
        in_valid = 1'b0;
        if (taken) begin
            next_id++;
            sent_count++;
        end else begin
            $display("Timeout: request with id %0h was never accepted", in_req.id);
            timed_out = 1'b1;
            error_count++;
        end
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_id.size() != 0 && waited < TIMEOUT) begin
            @(negedge clk);
            drive_ready();
            waited++;
        end
        if (exp_id.size() != 0) begin
            $display("Timeout: %0d results never came out", exp_id.size());
            timed_out = 1'b1;
            error_count++;
        end
    endtask

    task automatic begin_test();
        test_count++;
        errors_at_start  = error_count;
        results_at_start = result_count;
        sent_at_start    = sent_count;
    endtask

    task automatic end_test(input string name);
        int errs;
        errs = error_count - errors_at_start;
        $display("test %0d %-18s %s: %0d sent, %0d results, %0d errors", test_count, name,
                 (errs == 0) ? "ok" : "FAILED", sent_count - sent_at_start,
                 result_count - results_at_start, errs);
    endtask

    // Every accepted request becomes one expected result
    always @(posedge clk) begin
        if (rst_n && in_valid && in_ready) begin
            exp_id.push_back(in_req.id);
            exp_data.push_back(ref_result(in_req.op, in_req.a, in_req.b));
        end
    end

    always @(posedge clk) begin
        if (rst_n && out_valid && out_ready) begin
            if (exp_id.size() == 0) begin
                $display("Result with id %0h came out with no request pending", out_res.id);
                error_count++;
            end else begin
                head_id   = exp_id.pop_front();
                head_data = exp_data.pop_front();
                check_count++;
                if (out_res.id !== head_id)
                    report_mismatch("out_res_o.id", 64'(out_res.id), 64'(head_id));
                if (out_res.data !== head_data)
                    report_mismatch("out_res_o.data", 64'(out_res.data), 64'(head_data));
            end
            result_count++;
        end else if (rst_n && !out_valid && out_res !== '0) begin
            report_mismatch("out_res_o", 64'(out_res), 64'(0));
        end
    end

    initial begin : main_sequence
        int waited;
        int accepted;
        bit took;
        logic [31:0] r;
        rng_state  = 32'd46;
        ready_mode = READY_HIGH;
        in_valid   = 1'b0;
        in_req     = '0;
        out_ready  = 1'b1;
        next_id    = '0;
        timed_out  = 1'b0;
        error_count = 0;
        check_count = 0;
        result_count = 0;
        sent_count = 0;
        test_count = 0;

        waited = 0;
        @(negedge clk);
        while (!rst_n && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (!rst_n) begin
            $display("Timeout: reset was never released");
            timed_out = 1'b1;
            error_count++;
        end

        if (!timed_out) begin
            begin_test();
            @(negedge clk);
            check_count += 2;
            if (out_valid !== 1'b0)
                report_mismatch("out_valid_o", 64'(out_valid), 64'(0));
            if (in_ready !== 1'b1)
                report_mismatch("in_ready_o", 64'(in_ready), 64'(1));
            end_test("reset state");
        end

        if (!timed_out) begin
            begin_test();
            for (int i = 0; i < 24 && !timed_out; i++) begin
                r = next_rand();
                send_request(unit_pkg::op_e'(3'(r % 32'd5)));
            end
            wait_drain();
            end_test("alu ops");
        end

        if (!timed_out) begin
            begin_test();
            for (int i = 0; i < 24 && !timed_out; i++) begin
                r = next_rand();
                send_request(r[4] ? unit_pkg::OP_MULH : unit_pkg::OP_MUL);
            end
            wait_drain();
            end_test("mul ops");
        end

        // A slow multiply ahead of fast ALU ops must still leave first
        if (!timed_out) begin
            begin_test();
            for (int i = 0; i < 6 && !timed_out; i++) begin
                send_request((i % 2 == 0) ? unit_pkg::OP_MUL : unit_pkg::OP_MULH);
                for (int k = 0; k < 3 && !timed_out; k++) begin
                    r = next_rand();
                    send_request(unit_pkg::op_e'(3'(r % 32'd5)));
                end
            end
            wait_drain();
            end_test("result order");
        end

        if (!timed_out) begin
            begin_test();
            ready_mode = READY_RANDOM;
            for (int i = 0; i < 48 && !timed_out; i++) begin
                r = next_rand();
                send_request(unit_pkg::op_e'(3'(r % 32'd7)));
            end
            wait_drain();
            ready_mode = READY_HIGH;
            drive_ready();
            check_count++;
            if ((result_count - results_at_start) != (sent_count - sent_at_start)) begin
                $display("Random back-pressure: %0d requests sent but %0d results came out",
                         sent_count - sent_at_start, result_count - results_at_start);
                error_count++;
            end
            end_test("back-pressure");
        end

        // Offer requests every cycle while the output is blocked
        if (!timed_out) begin
            begin_test();
            ready_mode = READY_LOW;
            drive_ready();
            accepted = 0;
            load_request(unit_pkg::OP_MULH);
            in_valid = 1'b1;
            for (int c = 0; c < 4 * QUEUE_DEPTH + 8; c++) begin
                @(posedge clk);
                took = in_ready;
                @(negedge clk);
                if (took) begin
                    accepted++;
                    next_id++;
                    sent_count++;
                    load_request((accepted % 4 == 3) ? unit_pkg::OP_XOR : unit_pkg::OP_MULH);
                end
            end
            check_count += 2;
            if (in_ready !== 1'b0)
                report_mismatch("in_ready_o", 64'(in_ready), 64'(0));
            in_valid = 1'b0;
            if (accepted > QUEUE_DEPTH) begin
                $display("Accepted %0d requests with out_ready_i low, more than %0d",
                         accepted, QUEUE_DEPTH);
                error_count++;
            end
            ready_mode = READY_HIGH;
            drive_ready();
            wait_drain();
            end_test("queue limit");
        end

        $display("Summary: %0d tests, %0d checks, %0d results, %0d errors",
                 test_count, check_count, result_count, error_count);
        if (error_count == 0 && !timed_out) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
